/* hdl/cycle_counter.sv */
`timescale 1ns/1ns

module cycle_counter
(
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    output mm_ctrl_pkg::cycle_t count
);

    // Counts cycles since the last clear and sticks at the top value,
    // so a long wait in one state never wraps back to a phase boundary
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            count <= '0;
        end
        else if (count != '1)
        begin
            count <= count + 1'b1;
        end
    end

endmodule

/* hdl/mac_pe.sv */
`timescale 1ns/1ns

module mac_pe
(
    input  logic               clk,
    input  logic               reset,
    input  logic               clear,
    input  mm_data_pkg::elem_t in_a,
    input  mm_data_pkg::elem_t in_b,
    output mm_data_pkg::elem_t out_a,
    output mm_data_pkg::elem_t out_b,
    output mm_data_pkg::elem_t acc
);

    import mm_data_pkg::*;

    elem_t prod;

    // The product keeps only the low element bits, so it wraps like the sum
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            out_a <= '0;
            out_b <= '0;
            prod  <= '0;
            acc   <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
            prod  <= in_a * in_b;
            acc   <= acc + prod;
        end
    end

endmodule

/* hdl/matmul_4x4_systolic.sv */
`timescale 1ns/1ns

module matmul_4x4_systolic
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  mm_data_pkg::addr_t   address_mat_a,
    input  mm_data_pkg::addr_t   address_mat_b,
    input  mm_data_pkg::addr_t   address_mat_c,
    input  mm_data_pkg::stride_t address_stride_a,
    input  mm_data_pkg::stride_t address_stride_b,
    input  mm_data_pkg::stride_t address_stride_c,
    input  mm_data_pkg::mask_t   validity_mask_a_rows,
    input  mm_data_pkg::mask_t   validity_mask_a_cols_b_rows,
    input  mm_data_pkg::mask_t   validity_mask_b_cols,
    output mm_data_pkg::addr_t   a_addr,
    input  mm_data_pkg::word_t   a_data,
    output mm_data_pkg::addr_t   b_addr,
    input  mm_data_pkg::word_t   b_data,
    output mm_data_pkg::word_t   c_data,
    output mm_data_pkg::addr_t   c_addr,
    output logic                 c_data_available,
    output logic                 done
);

    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    cycle_t       count;
    logic         timer_clear;
    phase_t       phase;
    lane_vec_t    a_edge;
    lane_vec_t    b_edge;
    result_grid_t results;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    cycle_counter u_cycle_counter
    (
        .clk   (clk),
        .reset (reset),
        .clear (timer_clear),
        .count (count)
    );

    matmul_ctrl_fsm u_matmul_ctrl_fsm
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .count       (count),
        .timer_clear (timer_clear),
        .phase       (phase),
        .done        (done)
    );

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    operand_skew u_operand_skew
    (
        .clk                         (clk),
        .reset                       (reset),
        .phase                       (phase),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .a_edge                      (a_edge),
        .b_edge                      (b_edge)
    );

    pe_grid u_pe_grid
    (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .a_edge  (a_edge),
        .b_edge  (b_edge),
        .results (results)
    );

    result_unloader u_result_unloader
    (
        .clk              (clk),
        .reset            (reset),
        .phase            (phase),
        .results          (results),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_data           (c_data),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

/* hdl/matmul_ctrl_fsm.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module matmul_ctrl_fsm
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  mm_ctrl_pkg::cycle_t count,
    output logic                timer_clear,
    output mm_ctrl_pkg::phase_t phase,
    output logic                done
);

    import mm_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Dropping start aborts a run from any busy state
    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (start)
                    state_next = st_fetch;
            st_fetch:
                if (!start)
                    state_next = st_idle;
                else if (count == cycle_t'(`MM_FETCH_CYCLES - 1))
                    state_next = st_compute;
            st_compute:
                if (!start)
                    state_next = st_idle;
                else if (count == cycle_t'(`MM_COMPUTE_CYCLES - 1))
                    state_next = st_unload;
            st_unload:
                if (!start)
                    state_next = st_idle;
                else if (count == cycle_t'(`MM_UNLOAD_CYCLES - 1))
                    state_next = st_finish;
            st_finish:
                if (!start)
                    state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    // Every state starts with the timer at zero
    assign timer_clear = (state == st_idle) || (state_next != state);

    always_comb
    begin
        phase          = '0;
        phase.pe_clear = (state == st_idle);
        phase.fetch_en = (state == st_fetch);
        phase.capture  = (state == st_compute) && (count == cycle_t'(`MM_COMPUTE_CYCLES - 1));
        phase.shift_en = (state == st_unload);
    end

    // The timer saturates in finish, so zero is seen only on entry
    assign done = (state == st_finish) && (count == '0);

endmodule

/* hdl/mm_ctrl_pkg.sv */
package mm_ctrl_pkg;

    typedef enum logic [2:0]
    {
        st_idle,
        st_fetch,
        st_compute,
        st_unload,
        st_finish
    } ctrl_state_t;

    // Phase timer value, wide enough for the longest phase
    typedef logic [4:0] cycle_t;

    // Per-cycle strobes from the controller to the data path
    typedef struct packed
    {
        logic fetch_en;
        logic pe_clear;
        logic capture;
        logic shift_en;
    } phase_t;

endpackage

/* hdl/mm_data_pkg.sv */
`include "systolic_cfg.svh"

package mm_data_pkg;

    // One matrix element
    typedef logic [`MM_DWIDTH-1:0] elem_t;

    // One memory word of MM_SIZE elements, lane 0 in the low bits
    typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] word_t;

    typedef logic [`MM_AWIDTH-1:0] addr_t;
    typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;

    // One validity bit per lane or per word index
    typedef logic [`MM_SIZE-1:0] mask_t;

    // Operand edge of the grid, one element per row or column
    typedef elem_t [`MM_SIZE-1:0] lane_vec_t;

    // Accumulator values, indexed as [row][column]
    typedef lane_vec_t [`MM_SIZE-1:0] result_grid_t;

endpackage

/* hdl/operand_skew.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module operand_skew
(
    input  logic                   clk,
    input  logic                   reset,
    input  mm_ctrl_pkg::phase_t    phase,
    input  mm_data_pkg::addr_t     address_mat_a,
    input  mm_data_pkg::addr_t     address_mat_b,
    input  mm_data_pkg::stride_t   address_stride_a,
    input  mm_data_pkg::stride_t   address_stride_b,
    input  mm_data_pkg::word_t     a_data,
    input  mm_data_pkg::word_t     b_data,
    input  mm_data_pkg::mask_t     validity_mask_a_rows,
    input  mm_data_pkg::mask_t     validity_mask_a_cols_b_rows,
    input  mm_data_pkg::mask_t     validity_mask_b_cols,
    output mm_data_pkg::addr_t     a_addr,
    output mm_data_pkg::addr_t     b_addr,
    output mm_data_pkg::lane_vec_t a_edge,
    output mm_data_pkg::lane_vec_t b_edge
);

    import mm_data_pkg::*;

    localparam int IDX_W = $clog2(`MM_SIZE);
    localparam int LAT = `MM_MEM_LATENCY;

    logic [IDX_W-1:0] fetch_idx;
    logic [LAT-1:0]   valid_pipe;
    logic [IDX_W-1:0] idx_pipe [LAT];
    logic             word_ok;
    lane_vec_t        a_masked;
    lane_vec_t        b_masked;

    //////////////////////////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !phase.fetch_en)
        begin
            fetch_idx <= '0;
        end
        else
        begin
            fetch_idx <= fetch_idx + 1'b1;
        end
    end

    // Back to the base after the last word so the next fetch starts there
    always_ff @(posedge clk)
    begin
        if (reset || !phase.fetch_en || fetch_idx == IDX_W'(`MM_SIZE - 1))
        begin
            a_addr <= address_mat_a;
            b_addr <= address_mat_b;
        end
        else
        begin
            a_addr <= a_addr + addr_t'(address_stride_a);
            b_addr <= b_addr + addr_t'(address_stride_b);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Returning data qualification
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe[0] <= phase.fetch_en;
            for (int s = 1; s < LAT; s++)
                valid_pipe[s] <= valid_pipe[s-1];
        end
    end

    always_ff @(posedge clk)
    begin
        idx_pipe[0] <= fetch_idx;
        for (int s = 1; s < LAT; s++)
            idx_pipe[s] <= idx_pipe[s-1];
    end

    // A column of A and a row of B share one inner index, hence one mask bit
    assign word_ok = valid_pipe[LAT-1] && validity_mask_a_cols_b_rows[idx_pipe[LAT-1]];

    always_comb
    begin
        for (int n = 0; n < `MM_SIZE; n++)
        begin
            a_masked[n] = (word_ok && validity_mask_a_rows[n]) ?
                          a_data[n*`MM_DWIDTH +: `MM_DWIDTH] : '0;
            b_masked[n] = (word_ok && validity_mask_b_cols[n]) ?
                          b_data[n*`MM_DWIDTH +: `MM_DWIDTH] : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Skew, lane n delayed by n cycles
    //////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < `MM_SIZE; n++)
    begin : g_lane
        if (n == 0)
        begin : g_direct
            assign a_edge[n] = a_masked[n];
            assign b_edge[n] = b_masked[n];
        end
        else
        begin : g_delay
            elem_t a_chain [n];
            elem_t b_chain [n];

            always_ff @(posedge clk)
            begin
                if (reset || phase.pe_clear)
                begin
                    for (int s = 0; s < n; s++)
                    begin
                        a_chain[s] <= '0;
                        b_chain[s] <= '0;
                    end
                end
                else
                begin
                    a_chain[0] <= a_masked[n];
                    b_chain[0] <= b_masked[n];
                    for (int s = 1; s < n; s++)
                    begin
                        a_chain[s] <= a_chain[s-1];
                        b_chain[s] <= b_chain[s-1];
                    end
                end
            end

            assign a_edge[n] = a_chain[n-1];
            assign b_edge[n] = b_chain[n-1];
        end
    end

endmodule

/* hdl/pe_grid.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module pe_grid
(
    input  logic                      clk,
    input  logic                      reset,
    input  mm_ctrl_pkg::phase_t       phase,
    input  mm_data_pkg::lane_vec_t    a_edge,
    input  mm_data_pkg::lane_vec_t    b_edge,
    output mm_data_pkg::result_grid_t results
);

    import mm_data_pkg::*;

    // a_link[i][j] feeds PE(i,j) from the west, b_link[i][j] from the north.
    // The extra column and row catch what leaves the east and south edges
    elem_t a_link [`MM_SIZE][`MM_SIZE+1];
    elem_t b_link [`MM_SIZE+1][`MM_SIZE];

    for (genvar n = 0; n < `MM_SIZE; n++)
    begin : g_edge
        assign a_link[n][0] = a_edge[n];
        assign b_link[0][n] = b_edge[n];
    end

    //////////////////////////////////////////////////////////////////////
    // Mesh, A moves right and B moves down one PE per cycle
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `MM_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < `MM_SIZE; j++)
        begin : g_col
            mac_pe u_mac_pe
            (
                .clk   (clk),
                .reset (reset),
                .clear (phase.pe_clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (results[i][j])
            );
        end
    end

endmodule

/* hdl/result_unloader.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module result_unloader
(
    input  logic                      clk,
    input  logic                      reset,
    input  mm_ctrl_pkg::phase_t       phase,
    input  mm_data_pkg::result_grid_t results,
    input  mm_data_pkg::addr_t        address_mat_c,
    input  mm_data_pkg::stride_t      address_stride_c,
    output mm_data_pkg::word_t        c_data,
    output mm_data_pkg::addr_t        c_addr,
    output logic                      c_data_available
);

    import mm_data_pkg::*;

    // Column words waiting to go out, the head is entry 0
    word_t col_sr [`MM_SIZE];

    always_ff @(posedge clk)
    begin
        if (phase.capture)
        begin
            for (int j = 0; j < `MM_SIZE; j++)
                for (int i = 0; i < `MM_SIZE; i++)
                    col_sr[j][i*`MM_DWIDTH +: `MM_DWIDTH] <= results[i][j];
            c_addr <= address_mat_c;
        end
        else if (phase.shift_en)
        begin
            for (int j = 0; j < `MM_SIZE - 1; j++)
                col_sr[j] <= col_sr[j+1];
            col_sr[`MM_SIZE-1] <= '0;
            c_addr <= c_addr + addr_t'(address_stride_c);
        end
    end

    assign c_data = col_sr[0];

    // Valid for exactly the unload phase, one column per cycle
    assign c_data_available = phase.shift_en && !reset;

endmodule

/* hdl/systolic_cfg.svh */
`ifndef SYSTOLIC_CFG_SVH
`define SYSTOLIC_CFG_SVH

// Array dimension, one PE row and one PE column per element index
`define MM_SIZE 4

// Element width, with arithmetic wrapping modulo 2**MM_DWIDTH
`define MM_DWIDTH 8
`define MM_AWIDTH 10
`define MM_STRIDE_WIDTH 8

// Read latency of the A and B memories in clock cycles
`define MM_MEM_LATENCY 1

// Phase lengths in clock cycles
`define MM_FETCH_CYCLES 4
// From the end of fetch until the last PE holds its final sum
`define MM_COMPUTE_CYCLES 12
`define MM_UNLOAD_CYCLES 4

`endif

/* matmul_4x4_systolic.f */
+incdir+hdl
hdl/mm_data_pkg.sv
hdl/mm_ctrl_pkg.sv
hdl/cycle_counter.sv
hdl/matmul_ctrl_fsm.sv
hdl/operand_skew.sv
hdl/mac_pe.sv
hdl/pe_grid.sv
hdl/result_unloader.sv
hdl/matmul_4x4_systolic.sv
verif/matmul_checker.sv
verif/tb_matmul_4x4.sv

/* verif/matmul_checker.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module matmul_checker
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  mm_data_pkg::addr_t   address_mat_a,
    input  mm_data_pkg::addr_t   address_mat_b,
    input  mm_data_pkg::addr_t   address_mat_c,
    input  mm_data_pkg::stride_t address_stride_a,
    input  mm_data_pkg::stride_t address_stride_b,
    input  mm_data_pkg::stride_t address_stride_c,
    input  mm_data_pkg::mask_t   validity_mask_a_rows,
    input  mm_data_pkg::mask_t   validity_mask_a_cols_b_rows,
    input  mm_data_pkg::mask_t   validity_mask_b_cols,
    input  mm_data_pkg::addr_t   a_addr,
    input  mm_data_pkg::word_t   a_data,
    input  mm_data_pkg::addr_t   b_addr,
    input  mm_data_pkg::word_t   b_data,
    input  mm_data_pkg::word_t   c_data,
    input  mm_data_pkg::addr_t   c_addr,
    input  logic                 c_data_available,
    input  logic                 done,
    output int                   check_count,
    output int                   error_count
);

    import mm_data_pkg::*;

    // Cycles seen with start high and sampled on the falling edge
    int    run_cnt;
    int    word_idx;
    elem_t a_mat [`MM_SIZE][`MM_SIZE];
    elem_t b_mat [`MM_SIZE][`MM_SIZE];

    initial
    begin
        check_count = 0;
        error_count = 0;
        run_cnt     = 0;
        word_idx    = 0;
    end

    function automatic addr_t strided_addr(input addr_t base, input stride_t stride, input int k);
        return addr_t'(int'(base) + k * int'(stride));
    endfunction

    // Column j of C holds row i in lane i with every sum taken modulo 256
    function automatic word_t expected_column(input int j);
        word_t       w;
        elem_t       sum;
        logic [15:0] prod;
        w = '0;
        for (int i = 0; i < `MM_SIZE; i++)
        begin
            sum = '0;
            for (int k = 0; k < `MM_SIZE; k++)
            begin
                prod = a_mat[i][k] * b_mat[k][j];
                if (validity_mask_a_rows[i] && validity_mask_a_cols_b_rows[k] &&
                    validity_mask_b_cols[j])
                    sum = sum + prod[`MM_DWIDTH-1:0];
            end
            w[i*`MM_DWIDTH +: `MM_DWIDTH] = sum;
        end
        return w;
    endfunction

    task automatic verify_fetch_addr(input int k);
        addr_t exp_a;
        addr_t exp_b;
        exp_a = strided_addr(address_mat_a, address_stride_a, k);
        exp_b = strided_addr(address_mat_b, address_stride_b, k);
        check_count = check_count + 2;
        if (a_addr !== exp_a)
        begin
            $display("Mismatch at %0t: a_addr %0d for word %0d, expected %0d",
                     $time, a_addr, k, exp_a);
            error_count++;
        end
        if (b_addr !== exp_b)
        begin
            $display("Mismatch at %0t: b_addr %0d for word %0d, expected %0d",
                     $time, b_addr, k, exp_b);
            error_count++;
        end
    endtask

    // Word k of A is column k and word k of B is row k
    task automatic capture_word(input int k);
        for (int n = 0; n < `MM_SIZE; n++)
        begin
            a_mat[n][k] = a_data[n*`MM_DWIDTH +: `MM_DWIDTH];
            b_mat[k][n] = b_data[n*`MM_DWIDTH +: `MM_DWIDTH];
        end
    endtask

    task automatic compare_output_word();
        word_t exp_w;
        addr_t exp_addr;
        if (word_idx >= `MM_UNLOAD_CYCLES)
        begin
            $display("More than %0d output words arrived in one run, extra word at %0t",
                     `MM_UNLOAD_CYCLES, $time);
            error_count++;
        end
        else
        begin
            exp_w    = expected_column(word_idx);
            exp_addr = strided_addr(address_mat_c, address_stride_c, word_idx);
            check_count = check_count + 2;
            if (c_data !== exp_w)
            begin
                $display("Mismatch at %0t: c_data word %0d is %h, expected %h",
                         $time, word_idx, c_data, exp_w);
                error_count++;
            end
            if (c_addr !== exp_addr)
            begin
                $display("Mismatch at %0t: c_addr for word %0d is %0d, expected %0d",
                         $time, word_idx, c_addr, exp_addr);
                error_count++;
            end
        end
        word_idx++;
    endtask

    task automatic close_run();
        check_count++;
        if (word_idx != `MM_UNLOAD_CYCLES)
        begin
            $display("Run finished at %0t with %0d output words instead of %0d",
                     $time, word_idx, `MM_UNLOAD_CYCLES);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Fetch starts one cycle after start is seen and data follows one later
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (reset)
        begin
            run_cnt  = 0;
            word_idx = 0;
        end
        else
        begin
            run_cnt = start ? run_cnt + 1 : 0;
            if (run_cnt == 1)
                word_idx = 0;
            if (run_cnt >= 2 && run_cnt < 2 + `MM_FETCH_CYCLES)
                verify_fetch_addr(run_cnt - 2);
            if (run_cnt >= 2 + `MM_MEM_LATENCY &&
                run_cnt < 2 + `MM_MEM_LATENCY + `MM_FETCH_CYCLES)
                capture_word(run_cnt - 2 - `MM_MEM_LATENCY);
            if (run_cnt == 0)
            begin
                check_count++;
                if (done || c_data_available)
                begin
                    $display("Mismatch at %0t: done %b c_data_available %b, expected 0 when idle",
                             $time, done, c_data_available);
                    error_count++;
                end
            end
            else
            begin
                if (c_data_available)
                    compare_output_word();
                if (done)
                    close_run();
            end
        end
    end

endmodule

/* verif/tb_matmul_4x4.sv */
`timescale 1ns/1ns
`include "systolic_cfg.svh"

module tb_matmul_4x4;

    import mm_data_pkg::*;

    localparam int NUM_TESTS      = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 100;
    localparam int MEM_WORDS      = 2 ** `MM_AWIDTH;

    localparam logic [1:0] FILL_IDENTITY = 2'd0;
    localparam logic [1:0] FILL_ONES     = 2'd1;
    localparam logic [1:0] FILL_RANDOM   = 2'd2;

    typedef struct packed
    {
        logic [1:0] fill;
        mask_t      a_rows;
        mask_t      inner;
        mask_t      b_cols;
        addr_t      base_a;
        addr_t      base_b;
        addr_t      base_c;
        stride_t    stride_a;
        stride_t    stride_b;
        stride_t    stride_c;
    } test_entry_t;

    logic    clk;
    logic    reset;
    logic    start;
    addr_t   address_mat_a;
    addr_t   address_mat_b;
    addr_t   address_mat_c;
    stride_t address_stride_a;
    stride_t address_stride_b;
    stride_t address_stride_c;
    mask_t   validity_mask_a_rows;
    mask_t   validity_mask_a_cols_b_rows;
    mask_t   validity_mask_b_cols;
    addr_t   a_addr;
    addr_t   b_addr;
    word_t   a_data;
    word_t   b_data;
    word_t   c_data;
    addr_t   c_addr;
    logic    c_data_available;
    logic    done;

    word_t       mem_a [MEM_WORDS];
    word_t       mem_b [MEM_WORDS];
    test_entry_t tests [NUM_TESTS];
    int          seed;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          errors_before;
    int          tests_passed;
    int          tests_failed;

    matmul_4x4_systolic u_matmul_4x4_systolic
    (
        .clk                         (clk),
        .reset                       (reset),
        .start                       (start),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_mat_c               (address_mat_c),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .address_stride_c            (address_stride_c),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .a_data                      (a_data),
        .b_addr                      (b_addr),
        .b_data                      (b_data),
        .c_data                      (c_data),
        .c_addr                      (c_addr),
        .c_data_available            (c_data_available),
        .done                        (done)
    );

    matmul_checker u_matmul_checker
    (
        .clk                         (clk),
        .reset                       (reset),
        .start                       (start),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_mat_c               (address_mat_c),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .address_stride_c            (address_stride_c),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .a_data                      (a_data),
        .b_addr                      (b_addr),
        .b_data                      (b_data),
        .c_data                      (c_data),
        .c_addr                      (c_addr),
        .c_data_available            (c_data_available),
        .done                        (done),
        .check_count                 (check_count),
        .error_count                 (error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Both memories answer one cycle after the address
    always @(posedge clk)
    begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    function automatic test_entry_t build_entry(
        input logic [1:0] fill, input mask_t a_rows, input mask_t inner, input mask_t b_cols,
        input int base_a, input int stride_a, input int base_b, input int stride_b,
        input int base_c, input int stride_c);
        test_entry_t e;
        e.fill     = fill;
        e.a_rows   = a_rows;
        e.inner    = inner;
        e.b_cols   = b_cols;
        e.base_a   = addr_t'(base_a);
        e.base_b   = addr_t'(base_b);
        e.base_c   = addr_t'(base_c);
        e.stride_a = stride_t'(stride_a);
        e.stride_b = stride_t'(stride_b);
        e.stride_c = stride_t'(stride_c);
        return e;
    endfunction

    function automatic string fill_name(input logic [1:0] fill);
        case (fill)
            FILL_IDENTITY: return "identity B";
            FILL_ONES:     return "all ones";
            default:       return "random";
        endcase
    endfunction

    // Background words differ at every address so a stray read shows up
    task automatic fill_background();
        for (int x = 0; x < MEM_WORDS; x++)
        begin
            mem_a[x] = word_t'(x * 32'h0100_4f1b) ^ 32'ha5c3_0000;
            mem_b[x] = word_t'(x * 32'h0301_0c27) ^ 32'h3c5a_0000;
        end
    endtask

    task automatic load_matrices(input test_entry_t e);
        word_t wa;
        word_t wb;
        elem_t va;
        elem_t vb;
        for (int k = 0; k < `MM_SIZE; k++)
        begin
            for (int n = 0; n < `MM_SIZE; n++)
            begin
                case (e.fill)
                    FILL_IDENTITY:
                    begin
                        va = elem_t'($random(seed));
                        vb = (n == k) ? elem_t'(1) : elem_t'(0);
                    end
                    FILL_ONES:
                    begin
                        va = elem_t'(1);
                        vb = elem_t'(1);
                    end
                    default:
                    begin
                        va = elem_t'($random(seed));
                        vb = elem_t'($random(seed));
                    end
                endcase
                wa[n*`MM_DWIDTH +: `MM_DWIDTH] = va;
                wb[n*`MM_DWIDTH +: `MM_DWIDTH] = vb;
            end
            mem_a[addr_t'(int'(e.base_a) + k * int'(e.stride_a))] = wa;
            mem_b[addr_t'(int'(e.base_b) + k * int'(e.stride_b))] = wb;
        end
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset                       = 1'b1;
        start                       = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_mat_c               = '0;
        address_stride_a            = '0;
        address_stride_b            = '0;
        address_stride_c            = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        a_data                      = '0;
        b_data                      = '0;
        seed                        = 32'hdb6a;
        tests_passed                = 0;
        tests_failed                = 0;

        tests[0] = build_entry(FILL_IDENTITY, 4'hf, 4'hf, 4'hf, 0, 1, 64, 1, 512, 4);
        tests[1] = build_entry(FILL_ONES, 4'hf, 4'hf, 4'hf, 16, 2, 32, 3, 600, 1);
        tests[2] = build_entry(FILL_RANDOM, 4'hf, 4'hf, 4'hf, 100, 3, 200, 5, 300, 7);
        tests[3] = build_entry(FILL_RANDOM, 4'hb, 4'hf, 4'h6, 40, 4, 80, 4, 700, 16);
        tests[4] = build_entry(FILL_RANDOM, 4'hf, 4'h5, 4'hf, 1020, 2, 1000, 9, 1016, 4);
        tests[5] = build_entry(FILL_ONES, 4'he, 4'hd, 4'h7, 300, 10, 400, 20, 10, 255);
        tests[6] = build_entry(FILL_IDENTITY, 4'hf, 4'hf, 4'hf, 500, 1, 500, 1, 900, 1);

        fill_background();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Quiet stretch before the first start
        repeat (5) @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            errors_before = error_count;
            load_matrices(tests[t]);
            @(posedge clk);
            address_mat_a               <= tests[t].base_a;
            address_mat_b               <= tests[t].base_b;
            address_mat_c               <= tests[t].base_c;
            address_stride_a            <= tests[t].stride_a;
            address_stride_b            <= tests[t].stride_b;
            address_stride_c            <= tests[t].stride_c;
            validity_mask_a_rows        <= tests[t].a_rows;
            validity_mask_a_cols_b_rows <= tests[t].inner;
            validity_mask_b_cols        <= tests[t].b_cols;
            start                       <= 1'b1;
            do
                @(negedge clk);
            while (!done);
            @(posedge clk);
            start <= 1'b0;
            repeat (2) @(posedge clk);
            if (error_count == errors_before)
            begin
                tests_passed++;
                $display("Test %0d (%s) passed", t, fill_name(tests[t].fill));
            end
            else
            begin
                tests_failed++;
                $display("Test %0d (%s) failed with %0d errors", t,
                         fill_name(tests[t].fill), error_count - errors_before);
            end
        end

        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
